/* Makefile */
TOP = cpuCoreTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f all.f \
		--top-module $(TOP) -o simv
	./obj_dir/simv | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* all.f */
rtl/opcodes.sv
rtl/alu.sv
rtl/regFile.sv
rtl/datapath.sv
rtl/control.sv
rtl/cpuCore.sv
tests/clockGen.sv
tests/cpuCoreTb.sv

/* rtl/alu.sv */
// Combinational 16-bit ALU with Z, C, N and V flag generation
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  opcodes::wordT        a,
  input  opcodes::wordT        b,
  input  opcodes::aluFunctionT op,
  output opcodes::wordT        y,
  output opcodes::flagsT       flagsOut
);

  import opcodes::*;

  logic [16:0] sum;
  logic        carry;
  logic        overflow;

  always_comb begin
    sum = '0;
    y = b;
    carry = 1'b0;
    overflow = 1'b0;
    case (op)
      aluAdd: begin
        sum = {1'b0, a} + {1'b0, b};
        y = sum[15:0];
        carry = sum[16];
        overflow = (a[15] == b[15]) && (y[15] != a[15]);
      end
      aluSub: begin
        // Carry set means no borrow
        sum = {1'b0, a} + {1'b0, ~b} + 17'd1;
        y = sum[15:0];
        carry = sum[16];
        overflow = (a[15] != b[15]) && (y[15] != a[15]);
      end
      aluAnd: begin
        y = a & b;
      end
      aluOr: begin
        y = a | b;
      end
      aluXor: begin
        y = a ^ b;
      end
      default: begin
        y = b;
      end
    endcase
  end

  assign flagsOut = {(y == '0), carry, y[15], overflow};

endmodule

`default_nettype wire

/* rtl/control.sv */
// Multicycle control FSM with opcode decode and memory strobe generation
`timescale 1ns/1ps
`default_nettype none

module control (
  input  logic                 Clock,
  input  logic                 rst,
  input  opcodes::opcodeT      opcode,
  input  opcodes::flagsT       flags,
  input  logic                 nWait,
  output opcodes::aluFunctionT aluOp,
  output logic                 op2Sel,
  output logic                 pcWe,
  output logic                 pcSel,
  output logic                 irWe,
  output logic                 marWe,
  output logic                 addrSel,
  output logic                 regWe,
  output logic                 wdSel,
  output logic                 mdrWe,
  output logic                 flagWe,
  output logic                 busSel,
  output logic                 nOe,
  output logic                 nMe,
  output logic                 ale,
  output logic                 enb,
  output logic                 rnW,
  output logic                 halted
);

  import opcodes::*;

  cpuStateT    state;
  cpuStateT    stateNext;
  aluFunctionT aluDecoded;
  logic        started;
  logic        aleState;
  logic        isLoad;

  // Holds the first address phase until the cycle after reset
  always_ff @(posedge Clock) begin
    if (rst) begin
      state <= sFetchAddr;
      started <= 1'b0;
    end else begin
      state <= stateNext;
      started <= 1'b1;
    end
  end

  always_comb begin
    case (opcode)
      opAdd, opAddi: aluDecoded = aluAdd;
      opSub:         aluDecoded = aluSub;
      opAnd:         aluDecoded = aluAnd;
      opOr:          aluDecoded = aluOr;
      opXor:         aluDecoded = aluXor;
      default:       aluDecoded = aluPassB;
    endcase
  end

  assign isLoad = (opcode == opLdw);

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    stateNext = state;
    case (state)
      sFetchAddr: if (started) stateNext = sFetchData;
      sFetchData: if (nWait) stateNext = sDecode;
      sDecode: begin
        case (opcode)
          opLdw, opStw: stateNext = sMemAddr;
          opAdd, opSub, opAnd, opOr, opXor, opAddi, opBrz, opJmp: stateNext = sExecute;
          default: stateNext = sHalt;
        endcase
      end
      sExecute:   stateNext = sFetchAddr;
      sMemAddr:   stateNext = sMemData;
      sMemData:   if (nWait) stateNext = sWriteBack;
      sWriteBack: stateNext = sFetchAddr;
      default:    stateNext = sHalt;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Datapath controls and strobes
  ////////////////////////////////////////////////////////////

  always_comb begin
    aluOp = aluPassB;
    op2Sel = 1'b0;
    pcWe = 1'b0;
    pcSel = 1'b0;
    irWe = 1'b0;
    marWe = 1'b0;
    addrSel = 1'b0;
    regWe = 1'b0;
    wdSel = 1'b0;
    mdrWe = 1'b0;
    flagWe = 1'b0;
    busSel = 1'b0;
    nOe = 1'b1;
    nMe = 1'b1;
    aleState = 1'b0;
    enb = 1'b0;
    rnW = 1'b1;
    case (state)
      sFetchAddr: aleState = 1'b1;
      sFetchData: begin
        nMe = 1'b0;
        nOe = 1'b0;
        irWe = nWait;
        pcWe = nWait;
      end
      sDecode: begin
        // Effective address rs + offset
        aluOp = aluAdd;
        op2Sel = 1'b1;
        marWe = (opcode == opLdw) || (opcode == opStw);
      end
      sExecute: begin
        aluOp = aluDecoded;
        op2Sel = (opcode == opAddi);
        case (opcode)
          opBrz: begin
            pcSel = 1'b1;
            pcWe = flags[FlagZ];
          end
          opJmp: begin
            pcSel = 1'b1;
            pcWe = 1'b1;
          end
          default: begin
            regWe = 1'b1;
            flagWe = 1'b1;
          end
        endcase
      end
      sMemAddr: begin
        aleState = 1'b1;
        addrSel = 1'b1;
      end
      sMemData: begin
        nMe = 1'b0;
        op2Sel = 1'b1;
        if (isLoad) begin
          nOe = 1'b0;
          mdrWe = nWait;
        end else begin
          rnW = 1'b0;
          enb = 1'b1;
          busSel = 1'b1;
        end
      end
      sWriteBack: begin
        // A store uses this slot as bus turnaround
        regWe = isLoad;
        wdSel = 1'b1;
      end
      default: ;
    endcase
  end

  assign ale = aleState && started;
  assign halted = (state == sHalt);

  aleNotInData: assert property (@(posedge Clock) disable iff (rst)
    !(ale && !nMe));
  noReadWhileWrite: assert property (@(posedge Clock) disable iff (rst)
    !(!nOe && !rnW));
  enbOnlyOnWrite: assert property (@(posedge Clock) disable iff (rst)
    enb |-> (!rnW && !nMe));

endmodule

`default_nettype wire

/* rtl/cpuCore.sv */
// Core top level joining control and datapath to the memory bus
`timescale 1ns/1ps
`default_nettype none

module cpuCore #(
  parameter opcodes::wordT ResetVector = 16'h0000
) (
  input  logic          Clock,
  input  logic          rst,
  input  opcodes::wordT dataIn,
  input  logic          nWait,
  output opcodes::wordT dataOut,
  output logic          nOe,
  output logic          nMe,
  output logic          ale,
  output logic          enb,
  output logic          rnW,
  output logic          halted
);

  import opcodes::*;

  aluFunctionT aluOp;
  opcodeT      opcode;
  flagsT       flags;
  logic        op2Sel;
  logic        pcWe;
  logic        pcSel;
  logic        irWe;
  logic        marWe;
  logic        addrSel;
  logic        regWe;
  logic        wdSel;
  logic        mdrWe;
  logic        flagWe;
  logic        busSel;

  control control (
    .Clock   (Clock),
    .rst     (rst),
    .opcode  (opcode),
    .flags   (flags),
    .nWait   (nWait),
    .aluOp   (aluOp),
    .op2Sel  (op2Sel),
    .pcWe    (pcWe),
    .pcSel   (pcSel),
    .irWe    (irWe),
    .marWe   (marWe),
    .addrSel (addrSel),
    .regWe   (regWe),
    .wdSel   (wdSel),
    .mdrWe   (mdrWe),
    .flagWe  (flagWe),
    .busSel  (busSel),
    .nOe     (nOe),
    .nMe     (nMe),
    .ale     (ale),
    .enb     (enb),
    .rnW     (rnW),
    .halted  (halted)
  );

  datapath #(
    .ResetVector (ResetVector)
  ) datapath (
    .Clock   (Clock),
    .rst     (rst),
    .aluOp   (aluOp),
    .op2Sel  (op2Sel),
    .pcWe    (pcWe),
    .pcSel   (pcSel),
    .irWe    (irWe),
    .marWe   (marWe),
    .addrSel (addrSel),
    .regWe   (regWe),
    .wdSel   (wdSel),
    .mdrWe   (mdrWe),
    .flagWe  (flagWe),
    .busSel  (busSel),
    .dataIn  (dataIn),
    .dataOut (dataOut),
    .opcode  (opcode),
    .flags   (flags)
  );

endmodule

`default_nettype wire

/* rtl/datapath.sv */
// PC, IR, MAR, MDR, flag register, operand muxes and bus output mux
`timescale 1ns/1ps
`default_nettype none

module datapath #(
  parameter opcodes::wordT ResetVector = 16'h0000
) (
  input  logic                 Clock,
  input  logic                 rst,
  input  opcodes::aluFunctionT aluOp,
  input  logic                 op2Sel,
  input  logic                 pcWe,
  input  logic                 pcSel,
  input  logic                 irWe,
  input  logic                 marWe,
  input  logic                 addrSel,
  input  logic                 regWe,
  input  logic                 wdSel,
  input  logic                 mdrWe,
  input  logic                 flagWe,
  input  logic                 busSel,
  input  opcodes::wordT        dataIn,
  output opcodes::wordT        dataOut,
  output opcodes::opcodeT      opcode,
  output opcodes::flagsT       flags
);

  import opcodes::*;

  wordT   pc;
  wordT   ir;
  wordT   mar;
  wordT   mdr;
  wordT   immExt;
  wordT   brOff;
  wordT   pcNext;
  wordT   rdata1;
  wordT   rdata2;
  wordT   aluB;
  wordT   aluY;
  wordT   wdata;
  wordT   addrOut;
  flagsT  aluFlags;
  regIdxT rd;
  regIdxT rs;
  regIdxT rt;
  regIdxT raddr2;

  ////////////////////////////////////////////////////////////
  // Instruction fields
  ////////////////////////////////////////////////////////////

  assign opcode = opcodeT'(ir[15:12]);
  assign rd = ir[11:9];
  assign rs = ir[8:6];
  assign rt = ir[5:3];
  assign immExt = {{10{ir[5]}}, ir[5:0]};
  assign brOff = {{7{ir[8]}}, ir[8:0]};

  // Branch offset is relative to the already incremented PC
  assign pcNext = pcSel ? pc + brOff : pc + 16'd1;

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge Clock) begin
    if (rst) begin
      pc <= ResetVector;
      flags <= '0;
    end else begin
      if (pcWe) pc <= pcNext;
      if (flagWe) flags <= aluFlags;
    end
  end

  always_ff @(posedge Clock) begin
    if (irWe) ir <= dataIn;
    if (marWe) mar <= aluY;
    if (mdrWe) mdr <= dataIn;
  end

  // Immediate forms have no rt, so port 2 reads rd as store data
  assign raddr2 = op2Sel ? rd : rt;
  assign aluB = op2Sel ? immExt : rdata2;
  assign wdata = wdSel ? mdr : aluY;

  regFile regs (
    .Clock  (Clock),
    .rst    (rst),
    .we     (regWe),
    .waddr  (rd),
    .raddr1 (rs),
    .raddr2 (raddr2),
    .wdata  (wdata),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  alu alu (
    .a        (rdata1),
    .b        (aluB),
    .op       (aluOp),
    .y        (aluY),
    .flagsOut (aluFlags)
  );

  // Multiplexed bus
  assign addrOut = addrSel ? mar : pc;
  assign dataOut = busSel ? rdata2 : addrOut;

  noBranchOnFetch: assert property (@(posedge Clock) disable iff (rst)
    irWe |-> !pcSel);

endmodule

`default_nettype wire

/* rtl/opcodes.sv */
// Word, register index, opcode, ALU function, state and flag types
`default_nettype none

package opcodes;

  ////////////////////////////////////////////////////////////
  // Data types
  ////////////////////////////////////////////////////////////

  typedef logic [15:0] wordT;
  typedef logic [2:0] regIdxT;

  // Flag order is {Z, C, N, V}
  typedef logic [3:0] flagsT;

  localparam int FlagZ = 3;
  localparam int FlagC = 2;
  localparam int FlagN = 1;
  localparam int FlagV = 0;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // Major opcode in ir[15:12], unlisted codes decode as halt
  typedef enum logic [3:0] {
    opAdd  = 4'h0,
    opSub  = 4'h1,
    opAnd  = 4'h2,
    opOr   = 4'h3,
    opXor  = 4'h4,
    opAddi = 4'h5,
    opLdw  = 4'h6,
    opStw  = 4'h7,
    opBrz  = 4'h8,
    opJmp  = 4'h9,
    opHalt = 4'hf
  } opcodeT;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluPassB
  } aluFunctionT;

  typedef enum logic [2:0] {
    sFetchAddr,
    sFetchData,
    sDecode,
    sExecute,
    sMemAddr,
    sMemData,
    sWriteBack,
    sHalt
  } cpuStateT;

endpackage

`default_nettype wire

/* rtl/regFile.sv */
// Eight-entry register file, two async read ports, one sync write port
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  logic            Clock,
  input  logic            rst,
  input  logic            we,
  input  opcodes::regIdxT waddr,
  input  opcodes::regIdxT raddr1,
  input  opcodes::regIdxT raddr2,
  input  opcodes::wordT   wdata,
  output opcodes::wordT   rdata1,
  output opcodes::wordT   rdata2
);

  import opcodes::*;

  wordT regs [0:7];

  // r0 is never written so it stays at its reset value of zero
  always_ff @(posedge Clock) begin
    if (rst) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

  r0Stable: assert property (@(posedge Clock) disable iff (rst)
    (we && waddr == '0) |=> regs[0] == $past(regs[0]));

endmodule

`default_nettype wire

/* tests/clockGen.sv */
// Free-running testbench clock source
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
  parameter int PeriodNs = 100
) (
  output logic Clock
);

  initial begin
    Clock = 1'b0;
    forever #(PeriodNs / 2) Clock = ~Clock;
  end

endmodule

`default_nettype wire

/* tests/cpuCoreTb.sv */
// Testbench with memory model, stimulus table, reference model, checks and verdict
`timescale 1ns/1ps
`default_nettype none

module cpuCoreTb;

  import opcodes::*;

  localparam wordT ResetVector = 16'h0020;
  localparam int NumCases = 20;
  localparam int NumFixed = 12;
  localparam int ResetCycles = 4;
  // Worst case run is about 90 cycles, two waits on all 15 accesses
  localparam int CyclesPerCase = 100;
  localparam int CycleLimit = CyclesPerCase * NumCases;
  localparam int NumDraws = 512;

  // Data slots sit at r0 plus a negative offset, bus address 16'hfffX
  localparam logic [5:0] OffA = 6'h30;
  localparam logic [5:0] OffB = 6'h31;
  localparam logic [5:0] OffRes = 6'h32;
  localparam logic [5:0] OffZero = 6'h33;
  localparam logic [5:0] OffMark = 6'h34;
  localparam logic [7:0] SlotA = 8'hf0;
  localparam logic [7:0] SlotB = 8'hf1;
  localparam logic [7:0] SlotRes = 8'hf2;
  localparam logic [7:0] SlotZero = 8'hf3;
  localparam logic [7:0] SlotMark = 8'hf4;
  localparam logic [5:0] MarkerImm = 6'h15;
  localparam wordT MarkerWord = 16'h0015;

  logic Clock;
  logic rst;
  logic nWait;
  wordT dataIn;
  wordT dataOut;
  logic nOe;
  logic nMe;
  logic ale;
  logic enb;
  logic rnW;
  logic halted;

  wordT       mem [0:255];
  logic [7:0] busAddr;
  int         waitLeft;
  int         drawIdx;
  int         waitDraws [NumDraws];

  opcodeT opTab [NumCases];
  wordT   aTab [NumCases];
  wordT   bTab [NumCases];
  wordT   expTab [NumCases];
  logic   zeroTab [NumCases];

  int seed;
  int caseIdx;
  int cycleCount;
  int valueErrors;
  int busErrors;

  clockGen #(.PeriodNs(100)) clockSource (.Clock(Clock));

  cpuCore #(
    .ResetVector (ResetVector)
  ) uut (
    .Clock   (Clock),
    .rst     (rst),
    .dataIn  (dataIn),
    .nWait   (nWait),
    .dataOut (dataOut),
    .nOe     (nOe),
    .nMe     (nMe),
    .ale     (ale),
    .enb     (enb),
    .rnW     (rnW),
    .halted  (halted)
  );

  ////////////////////////////////////////////////////////////
  // Instruction encoding and reference model
  ////////////////////////////////////////////////////////////

  function automatic wordT regInstr(opcodeT op, regIdxT rd, regIdxT rs, regIdxT rt);
    return {op, rd, rs, rt, 3'b000};
  endfunction

  function automatic wordT immInstr(opcodeT op, regIdxT rd, regIdxT rs, logic [5:0] imm);
    return {op, rd, rs, imm};
  endfunction

  function automatic wordT branchInstr(opcodeT op, logic [8:0] off);
    return {op, 3'b000, off};
  endfunction

  function automatic wordT refResult(opcodeT op, wordT a, wordT b);
    case (op)
      opAdd, opAddi: return a + b;
      opSub:         return a - b;
      opAnd:         return a & b;
      opOr:          return a | b;
      opXor:         return a ^ b;
      default:       return b;
    endcase
  endfunction

  task automatic addCase(input int idx, input opcodeT op, input wordT a, input wordT b);
    opTab[idx] = op;
    aTab[idx] = a;
    bTab[idx] = b;
    expTab[idx] = refResult(op, a, b);
    zeroTab[idx] = (expTab[idx] == 16'h0000);
  endtask

  task automatic buildTable();
    wordT r;
    // Carry, overflow, borrow and zero corners
    addCase(0, opAdd, 16'h0001, 16'h0002);
    addCase(1, opAdd, 16'hffff, 16'h0001);
    addCase(2, opAdd, 16'h7fff, 16'h0001);
    addCase(3, opSub, 16'h1234, 16'h1234);
    addCase(4, opSub, 16'h8000, 16'h0001);
    addCase(5, opSub, 16'h0000, 16'h0001);
    addCase(6, opAnd, 16'hf0f0, 16'h0f0f);
    addCase(7, opOr, 16'ha5a5, 16'h5a5a);
    addCase(8, opXor, 16'hffff, 16'hffff);
    addCase(9, opAddi, 16'h7fff, 16'h0001);
    addCase(10, opAddi, 16'h0005, 16'hfffb);
    addCase(11, opAddi, 16'h8000, 16'hffe0);
    for (int i = NumFixed; i < NumCases; i++) begin
      r = wordT'($random(seed));
      if (i % 6 == 5) begin
        addCase(i, opAddi, wordT'($random(seed)), {{10{r[5]}}, r[5:0]});
      end else begin
        addCase(i, opcodeT'(i % 6), wordT'($random(seed)), r);
      end
    end
    for (int i = 0; i < NumDraws; i++) begin
      waitDraws[i] = $unsigned($random(seed)) % 3;
    end
  endtask

  // ldw, ldw, marker setup, op, stw, op into r0, stw r0, brz, marker stw, halt
  task automatic loadProgram(input int idx);
    logic [7:0] base;
    wordT       opWord;
    wordT       r0Word;
    base = ResetVector[7:0];
    if (opTab[idx] == opAddi) begin
      opWord = immInstr(opAddi, 3'd3, 3'd1, bTab[idx][5:0]);
      r0Word = immInstr(opAddi, 3'd0, 3'd1, bTab[idx][5:0]);
    end else begin
      opWord = regInstr(opTab[idx], 3'd3, 3'd1, 3'd2);
      r0Word = regInstr(opTab[idx], 3'd0, 3'd1, 3'd2);
    end
    for (int i = 0; i < 256; i++) begin
      mem[i] = {i[7:0], ~i[7:0]};
    end
    mem[SlotA] = aTab[idx];
    mem[SlotB] = bTab[idx];
    mem[base] = immInstr(opLdw, 3'd1, 3'd0, OffA);
    mem[base + 8'd1] = immInstr(opLdw, 3'd2, 3'd0, OffB);
    mem[base + 8'd2] = immInstr(opAddi, 3'd4, 3'd0, MarkerImm);
    mem[base + 8'd3] = opWord;
    mem[base + 8'd4] = immInstr(opStw, 3'd3, 3'd0, OffRes);
    mem[base + 8'd5] = r0Word;
    mem[base + 8'd6] = immInstr(opStw, 3'd0, 3'd0, OffZero);
    mem[base + 8'd7] = branchInstr(opBrz, 9'd1);
    mem[base + 8'd8] = immInstr(opStw, 3'd4, 3'd0, OffMark);
    mem[base + 8'd9] = {opHalt, 12'h000};
  endtask

  ////////////////////////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////////////////////////

  // Program is reloaded on every reset cycle
  initial begin
    nWait = 1'b1;
    dataIn = '0;
    waitLeft = 0;
    drawIdx = 0;
    busAddr = '0;
    forever begin
      @(negedge Clock);
      if (rst) begin
        loadProgram(caseIdx);
        nWait = 1'b1;
        dataIn = '0;
      end else if (ale) begin
        busAddr = dataOut[7:0];
        waitLeft = waitDraws[drawIdx];
        drawIdx = (drawIdx + 1) % NumDraws;
        nWait = 1'b1;
        dataIn = '0;
      end else if (!nMe) begin
        // enb marks write data cycles only
        checkStrobe(enb, !rnW, "enb in data cycle");
        if (waitLeft > 0) begin
          waitLeft = waitLeft - 1;
          nWait = 1'b0;
        end else begin
          nWait = 1'b1;
          if (!rnW) mem[busAddr] = dataOut;
        end
        dataIn = nOe ? 16'h0000 : mem[busAddr];
      end else begin
        nWait = 1'b1;
        dataIn = '0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic checkWord(input wordT actual, input wordT expected, input string what);
    if (actual !== expected) begin
      valueErrors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic checkStrobe(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      valueErrors++;
      $display("Error at %0t ns: %s is %b, expected %b",
               $time, what, actual, expected);
    end
  endtask

  task automatic checkBranch(input logic present, input logic zeroResult, input int idx);
    if (present == zeroResult) begin
      valueErrors++;
      $display("Error at %0t ns: case %0d marker present %b with zero result %b",
               $time, idx, present, zeroResult);
    end
  endtask

  task automatic idleAfterReset();
    checkStrobe(ale, 1'b0, "ale in reset");
    checkStrobe(enb, 1'b0, "enb in reset");
    checkStrobe(halted, 1'b0, "halted in reset");
    checkStrobe(nOe, 1'b1, "nOe in reset");
    checkStrobe(nMe, 1'b1, "nMe in reset");
    checkStrobe(rnW, 1'b1, "rnW in reset");
  endtask

  task automatic runCase(input int idx);
    logic markerPresent;
    caseIdx = idx;
    @(negedge Clock);
    rst = 1'b1;
    repeat (ResetCycles) begin
      @(negedge Clock);
      idleAfterReset();
    end
    rst = 1'b0;
    while (!ale) @(negedge Clock);
    checkWord(dataOut, ResetVector, $sformatf("case %0d first fetch address", idx));
    while (!halted) @(negedge Clock);
    repeat (3) begin
      @(negedge Clock);
      if (ale || !nMe || !halted) begin
        busErrors++;
        $display("Bus activity after halt in case %0d at %0t ns", idx, $time);
      end
    end
    checkWord(mem[SlotRes], expTab[idx], $sformatf("case %0d stored result", idx));
    checkWord(mem[SlotZero], 16'h0000, $sformatf("case %0d stored r0", idx));
    markerPresent = (mem[SlotMark] == MarkerWord);
    checkBranch(markerPresent, zeroTab[idx], idx);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and timeout
  ////////////////////////////////////////////////////////////

  initial begin
    rst = 1'b1;
    seed = 32'h72d2;
    caseIdx = 0;
    valueErrors = 0;
    busErrors = 0;
    buildTable();
    for (int c = 0; c < NumCases; c++) begin
      runCase(c);
    end
    $display("Errors: %0d value, %0d bus", valueErrors, busErrors);
    if (valueErrors == 0 && busErrors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < CycleLimit) begin
      @(posedge Clock);
      cycleCount++;
    end
    $display("Timeout: run did not finish within %0d cycles", CycleLimit);
    $display("Errors: %0d value, %0d bus", valueErrors, busErrors);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire
